/* aluDecoder.sv */
`timescale 1ns/1ps

module aluDecoder (
	input  rvCtrlPkg::aluOpSel   ALUOp,
	input  rvIsaPkg::funct3Field funct3,
	input  rvIsaPkg::funct7Field funct7,
	output rvCtrlPkg::aluCtrl    ALUControl
);

	import rvIsaPkg::*;
	import rvCtrlPkg::*;

	always_comb begin
		case (ALUOp)
			aluOpAdd: ALUControl = aluAdd; // Address and PC arithmetic
			aluOpSub: ALUControl = aluSub; // beq compare
			default: begin
				case (funct3)
					// funct7 is already zero for I-type, so addi never subtracts
					f3AddSub: ALUControl = funct7[funct7SubBit] ? aluSub : aluAdd;
					f3Slt:    ALUControl = aluSlt;
					f3Or:     ALUControl = aluOr;
					f3And:    ALUControl = aluAnd;
					default:  ALUControl = aluAdd;
				endcase
			end
		endcase
	end

endmodule

/* aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
	input  rvIsaPkg::dataWord srcA,
	input  rvIsaPkg::dataWord srcB,
	input  rvCtrlPkg::aluCtrl ALUControl,
	output rvIsaPkg::dataWord aluResult,
	output logic              zero
);

	import rvCtrlPkg::*;

	always_comb begin
		case (ALUControl)
			aluAdd:  aluResult = srcA + srcB;
			aluSub:  aluResult = srcA - srcB;
			aluAnd:  aluResult = srcA & srcB;
			aluOr:   aluResult = srcA | srcB;
			aluSlt:  aluResult = {31'b0, $signed(srcA) < $signed(srcB)}; // Signed compare
			default: aluResult = srcA + srcB;
		endcase
	end

	assign zero = (aluResult == '0); // Equal operands on sub

endmodule

/* controlFsm.sv */
`timescale 1ns/1ps

module controlFsm (
	input  logic                  clk,
	input  logic                  rstN,
	input  rvIsaPkg::opcodeField  opcode,
	input  logic                  zero,
	output logic                  AdrSrc,
	output logic                  IRWrite,
	output logic                  RegWrite,
	output logic                  PCUpdate,
	output logic                  MemWrite,
	output logic                  Branch,
	output rvCtrlPkg::srcSel      ALUSrcA,
	output rvCtrlPkg::srcSel      ALUSrcB,
	output rvCtrlPkg::srcSel      ResultSrc,
	output rvCtrlPkg::aluOpSel    ALUOp
);

	import rvIsaPkg::*;
	import rvCtrlPkg::*;

	fsmState state;
	fsmState nextState;
	logic    pcUpdateState; // Unconditional PC write

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			state <= fetch;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = fetch;
		case (state)
			fetch: nextState = decode;
			decode: begin
				case (opcode)
					lwType, sType: nextState = memAdr;
					rType:         nextState = executeR;
					iType:         nextState = executeI;
					bType:         nextState = beqExec;
					jType:         nextState = jalExec;
					default:       nextState = fetch; // Unsupported opcode
				endcase
			end
			memAdr:   nextState = (opcode == lwType) ? memRead : memWrite;
			memRead:  nextState = memWb;
			executeR: nextState = aluWb;
			executeI: nextState = aluWb;
			jalExec:  nextState = aluWb; // Link write follows
			default:  nextState = fetch;
		endcase
	end

	// Moore outputs
	always_comb begin
		AdrSrc        = 1'b0;
		IRWrite       = 1'b0;
		RegWrite      = 1'b0;
		pcUpdateState = 1'b0;
		MemWrite      = 1'b0;
		Branch        = 1'b0;
		ALUSrcA       = srcAPc;
		ALUSrcB       = srcBReg;
		ResultSrc     = resAluOut;
		ALUOp         = aluOpAdd;
		case (state)
			fetch: begin
				IRWrite       = 1'b1;
				pcUpdateState = 1'b1; // PC + 4 straight from the ALU
				ALUSrcB       = srcBFour;
				ResultSrc     = resAluResult;
			end
			decode: begin
				ALUSrcA = srcAOldPc; // Branch or jump target into aluOut
				ALUSrcB = srcBImm;
			end
			memAdr: begin
				ALUSrcA = srcAReg;
				ALUSrcB = srcBImm;
			end
			memRead: AdrSrc = 1'b1;
			memWb: begin
				ResultSrc = resData;
				RegWrite  = 1'b1;
			end
			memWrite: begin
				AdrSrc   = 1'b1;
				MemWrite = 1'b1;
			end
			executeR: begin
				ALUSrcA = srcAReg;
				ALUOp   = aluOpFunct;
			end
			executeI: begin
				ALUSrcA = srcAReg;
				ALUSrcB = srcBImm;
				ALUOp   = aluOpFunct;
			end
			aluWb: RegWrite = 1'b1;
			beqExec: begin
				ALUSrcA = srcAReg;
				ALUOp   = aluOpSub;
				Branch  = 1'b1;
			end
			jalExec: begin
				ALUSrcA       = srcAOldPc; // Link value oldPC + 4
				ALUSrcB       = srcBFour;
				pcUpdateState = 1'b1;      // Target already in aluOut
			end
			default: ;
		endcase
	end

	assign PCUpdate = pcUpdateState | (Branch & zero); // Taken beq

endmodule

/* instructionDecode.sv */
`timescale 1ns/1ps

module instructionDecode (
	input  logic              clk,
	input  logic              rstN,
	input  rvIsaPkg::dataWord instr,
	input  rvIsaPkg::dataWord ResultData,
	input  logic              zero,
	output logic              AdrSrc,
	output logic              IRWrite,
	output logic              PCUpdate,
	output logic              MemWrite,
	output rvCtrlPkg::srcSel  ALUSrcA,
	output rvCtrlPkg::srcSel  ALUSrcB,
	output rvCtrlPkg::srcSel  ResultSrc,
	output rvCtrlPkg::aluCtrl ALUControl,
	output rvIsaPkg::dataWord immExt,
	output rvIsaPkg::dataWord baseAddr,
	output rvIsaPkg::dataWord writeData
);

	import rvIsaPkg::*;
	import rvCtrlPkg::*;

	opcodeField opcode;
	funct3Field funct3;
	funct7Field funct7;
	regIndex    rd;
	regIndex    rs1;
	regIndex    rs2;
	aluOpSel    aluOp;
	logic       regWrite;

	assign opcode = instr[6:0];

	// ALU function fields, only R-type keeps funct7
	always_comb begin
		funct3 = '0;
		funct7 = '0;
		if (opcode == rType) begin
			funct3 = instr[14:12];
			funct7 = instr[31:25];
		end else if (opcode == iType) begin
			funct3 = instr[14:12];
		end
	end

	// Register indices by format
	always_comb begin
		rd  = '0;
		rs1 = '0;
		rs2 = '0;
		case (opcode)
			rType: begin
				rd  = instr[11:7];
				rs1 = instr[19:15];
				rs2 = instr[24:20];
			end
			iType, lwType: begin
				rd  = instr[11:7];
				rs1 = instr[19:15];
			end
			sType, bType: begin
				rs1 = instr[19:15];
				rs2 = instr[24:20];
			end
			jType: rd = instr[11:7]; // Link register
			default: ;
		endcase
	end

	// Sign-extended immediates
	always_comb begin
		case (opcode)
			iType, lwType: immExt = {{20{instr[31]}}, instr[31:20]};
			sType:         immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			bType:         immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			jType:         immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			default:       immExt = '0;
		endcase
	end

	controlFsm i_controlFsm (
		.clk       (clk),
		.rstN      (rstN),
		.opcode    (opcode),
		.zero      (zero),
		.AdrSrc    (AdrSrc),
		.IRWrite   (IRWrite),
		.RegWrite  (regWrite),
		.PCUpdate  (PCUpdate),
		.MemWrite  (MemWrite),
		.Branch    (),          // Already folded into PCUpdate
		.ALUSrcA   (ALUSrcA),
		.ALUSrcB   (ALUSrcB),
		.ResultSrc (ResultSrc),
		.ALUOp     (aluOp)
	);

	aluDecoder i_aluDecoder (
		.ALUOp      (aluOp),
		.funct3     (funct3),
		.funct7     (funct7),
		.ALUControl (ALUControl)
	);

	registerFile i_registerFile (
		.clk       (clk),
		.rstN      (rstN),
		.Addr1     (rs1),
		.Addr2     (rs2),
		.Addr3     (rd),
		.regWrite  (regWrite),
		.dataIn    (ResultData),
		.baseAddr  (baseAddr),
		.writeData (writeData)
	);

endmodule

/* multiCycleCore.f */
rvIsaPkg.sv
rvCtrlPkg.sv
aluDecoder.sv
controlFsm.sv
registerFile.sv
instructionDecode.sv
aluUnit.sv
multiCycleCore.sv
multiCycleCore_checker.sv
multiCycleCore_tb.sv

/* multiCycleCore.sv */
`timescale 1ns/1ps

module multiCycleCore #(
	parameter rvIsaPkg::dataWord resetVector = 32'h0000_0000
) (
	input  logic              clk,
	input  logic              rstN,
	output rvIsaPkg::dataWord memAddr,
	output rvIsaPkg::dataWord memWriteData,
	output logic              memWrite,
	input  rvIsaPkg::dataWord memReadData
);

	import rvIsaPkg::*;
	import rvCtrlPkg::*;

	dataWord pc;
	dataWord oldPc;
	dataWord instrReg;
	dataWord data;
	dataWord a;
	dataWord b;
	dataWord aluOut;
	dataWord immExt;
	dataWord baseAddr;
	dataWord writeData;
	dataWord srcA;
	dataWord srcB;
	dataWord aluResult;
	dataWord result;
	aluCtrl  aluControl;
	srcSel   aluSrcA;
	srcSel   aluSrcB;
	srcSel   resultSrc;
	logic    adrSrc;
	logic    irWrite;
	logic    pcUpdate;
	logic    zero;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc       <= resetVector;
			instrReg <= '0;
		end else begin
			if (pcUpdate)
				pc <= result;
			if (irWrite)
				instrReg <= memReadData;
		end
	end

	// Non-architectural holding registers
	always_ff @(posedge clk) begin
		if (irWrite)
			oldPc <= pc; // Address of the fetched instruction
		data   <= memReadData;
		a      <= baseAddr;
		b      <= writeData;
		aluOut <= aluResult;
	end

	always_comb begin
		case (aluSrcA)
			srcAOldPc: srcA = oldPc;
			srcAReg:   srcA = a;
			default:   srcA = pc;
		endcase
		case (aluSrcB)
			srcBImm:  srcB = immExt;
			srcBFour: srcB = 32'd4;
			default:  srcB = b;
		endcase
		case (resultSrc)
			resData:      result = data;
			resAluResult: result = aluResult;
			default:      result = aluOut;
		endcase
	end

	assign memAddr      = adrSrc ? result : pc; // Data access or fetch
	assign memWriteData = b;

	instructionDecode i_instructionDecode (
		.clk        (clk),
		.rstN       (rstN),
		.instr      (instrReg),
		.ResultData (result),
		.zero       (zero),
		.AdrSrc     (adrSrc),
		.IRWrite    (irWrite),
		.PCUpdate   (pcUpdate),
		.MemWrite   (memWrite),
		.ALUSrcA    (aluSrcA),
		.ALUSrcB    (aluSrcB),
		.ResultSrc  (resultSrc),
		.ALUControl (aluControl),
		.immExt     (immExt),
		.baseAddr   (baseAddr),
		.writeData  (writeData)
	);

	aluUnit i_aluUnit (
		.srcA       (srcA),
		.srcB       (srcB),
		.ALUControl (aluControl),
		.aluResult  (aluResult),
		.zero       (zero)
	);

endmodule

/* multiCycleCore_checker.sv */
`timescale 1ns/1ps

module multiCycleCore_checker (
	input logic              clk,
	input logic              rstN,
	input rvIsaPkg::dataWord memAddr,
	input logic              memWrite
);

	// No store strobe while reset is held
	noWriteInReset: assert property (@(posedge clk) !rstN |-> !memWrite)
		else $error("memWrite was high during reset");

	// One memWrite state per sw
	singleCycleWrite: assert property (@(posedge clk) disable iff (!rstN)
		memWrite |=> !memWrite)
		else $error("memWrite was high on two consecutive cycles");

	wordAlignedWrite: assert property (@(posedge clk) disable iff (!rstN)
		memWrite |-> (memAddr[1:0] == 2'b00))
		else $error("Store address %h is not word-aligned", memAddr);

endmodule

bind multiCycleCore multiCycleCore_checker i_checker (
	.clk      (clk),
	.rstN     (rstN),
	.memAddr  (memAddr),
	.memWrite (memWrite)
);

/* multiCycleCore_tb.sv */
`timescale 1ns/1ps

module multiCycleCore_tb;

	import rvIsaPkg::*;

	localparam dataWord    resetVector = 32'h0000_0000;
	localparam int         memWords    = 256;
	localparam int         dataBase    = 'h200; // Random load region, 32 words
	localparam int         storeBase   = 'h300; // Where the program stores its results
	localparam funct7Field subF7       = 7'b0100000;

	logic    clk;
	logic    rstN;
	dataWord memAddr;
	dataWord memWriteData;
	logic    memWrite;
	dataWord memReadData = '0;

	dataWord progImage [memWords]; // Program and data as loaded at reset
	dataWord mem [memWords];
	dataWord expAddr [$];
	dataWord expData [$];
	int      progIdx    = 0;
	int      storeTotal = 0;
	int      storesSeen = 0;
	int      cycleCount = 0;
	int      cycleLimit = 0;
	int      nInstr;
	dataWord loopAddr;
	logic    pendWrite  = 1'b0;
	dataWord pendAddr   = '0;
	dataWord pendData   = '0;

	multiCycleCore #(.resetVector(resetVector)) i_multiCycleCore (
		.clk          (clk),
		.rstN         (rstN),
		.memAddr      (memAddr),
		.memWriteData (memWriteData),
		.memWrite     (memWrite),
		.memReadData  (memReadData)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Read data and store capture on the falling edge
	always @(negedge clk) begin
		memReadData = mem[memAddr[9:2]];
		pendWrite   = memWrite;
		pendAddr    = memAddr;
		pendData    = memWriteData;
	end

	always @(posedge clk) begin
		if (!rstN)
			mem = progImage; // Fresh image during reset
		else if (pendWrite)
			mem[pendAddr[9:2]] = pendData;
	end

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	// Instruction encoders
	function automatic dataWord encR(funct3Field f3, funct7Field f7, regIndex rd, regIndex rs1,
		regIndex rs2);
		return {f7, rs2, rs1, f3, rd, rType};
	endfunction

	function automatic dataWord encI(opcodeField op, funct3Field f3, regIndex rd, regIndex rs1,
		logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic dataWord encS(regIndex rs2, regIndex rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], sType};
	endfunction

	function automatic dataWord encB(regIndex rs1, regIndex rs2, logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], bType};
	endfunction

	function automatic dataWord encJ(regIndex rd, logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, jType};
	endfunction

	function automatic logic [11:0] wordOffset();
		return {5'b0, 5'($urandom_range(31, 0)), 2'b00};
	endfunction

	function automatic logic [11:0] negImm();
		return {1'b1, 11'($urandom)}; // Always below zero
	endfunction

	task automatic emit(input dataWord word);
		progImage[progIdx] = word;
		progIdx++;
	endtask

	task automatic buildProgram();
		for (int i = 0; i < memWords; i++)
			progImage[i] = {16'hC0DE, 16'(i * 4)}; // Byte address in the low half
		for (int i = 0; i < 32; i++)
			progImage[dataBase / 4 + i] = $urandom;
		emit(encI(iType, f3AddSub, 5'd10, 5'd0, 12'(dataBase)));
		emit(encI(iType, f3AddSub, 5'd11, 5'd0, 12'(storeBase)));
		emit(encI(lwType, 3'b010, 5'd1, 5'd10, wordOffset())); // lw is funct3 010
		emit(encI(lwType, 3'b010, 5'd2, 5'd10, wordOffset()));
		emit(encI(iType, f3AddSub, 5'd3, 5'd0, negImm())); // x3 below zero
		emit(encI(iType, f3AddSub, 5'd4, 5'd3, negImm())); // x4 differs from x3
		emit(encR(f3AddSub, 7'b0, 5'd5, 5'd1, 5'd2));
		emit(encS(5'd5, 5'd11, 12'd0));
		emit(encR(f3AddSub, subF7, 5'd6, 5'd1, 5'd2));
		emit(encS(5'd6, 5'd11, 12'd4));
		emit(encR(f3And, 7'b0, 5'd7, 5'd1, 5'd2));
		emit(encS(5'd7, 5'd11, 12'd8));
		emit(encR(f3Or, 7'b0, 5'd8, 5'd1, 5'd2));
		emit(encS(5'd8, 5'd11, 12'd12));
		emit(encR(f3Slt, 7'b0, 5'd9, 5'd1, 5'd2));
		emit(encS(5'd9, 5'd11, 12'd16));
		emit(encR(f3Slt, 7'b0, 5'd9, 5'd3, 5'd11)); // Negative against positive
		emit(encS(5'd9, 5'd11, 12'd20));
		// I-type, mostly with negative immediates
		emit(encI(iType, f3AddSub, 5'd12, 5'd1, negImm()));
		emit(encS(5'd12, 5'd11, 12'd24));
		emit(encI(iType, f3And, 5'd13, 5'd2, 12'($urandom)));
		emit(encS(5'd13, 5'd11, 12'd28));
		emit(encI(iType, f3Or, 5'd14, 5'd1, negImm()));
		emit(encS(5'd14, 5'd11, 12'd32));
		emit(encI(iType, f3Slt, 5'd15, 5'd4, 12'($urandom)));
		emit(encS(5'd15, 5'd11, 12'd36));
		emit(encI(lwType, 3'b010, 5'd16, 5'd10, wordOffset()));
		emit(encS(5'd16, 5'd11, 12'd40));
		emit(encB(5'd1, 5'd1, 13'd8)); // Taken, skips the next store
		emit(encS(5'd1, 5'd11, 12'd44));
		emit(encB(5'd3, 5'd4, 13'd8)); // Not taken
		emit(encS(5'd3, 5'd11, 12'd48));
		emit(encJ(5'd17, 21'd8));
		emit(encS(5'd2, 5'd11, 12'd52));
		emit(encS(5'd17, 5'd11, 12'd56)); // Link value
		emit(encI(iType, f3AddSub, 5'd0, 5'd1, 12'($urandom)));
		emit(encS(5'd0, 5'd11, 12'd60));
		loopAddr = 32'(progIdx * 4);
		emit(encJ(5'd0, 21'd0)); // Jump to self
	endtask

	function automatic dataWord refAlu(funct3Field f3, dataWord a, dataWord b, logic isSub);
		case (f3)
			f3AddSub: return isSub ? a - b : a + b;
			f3Slt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			f3Or:     return a | b;
			f3And:    return a & b;
			default:  return '0;
		endcase
	endfunction

	// ISA model of the subset, returns the number of executed instructions
	function automatic int refRun();
		dataWord regs [32];
		dataWord ram [memWords];
		dataWord pc;
		dataWord nextPc;
		dataWord instr;
		dataWord rs1v;
		dataWord rs2v;
		dataWord addr;
		dataWord res;
		logic    writeRd;
		logic    done;
		int      count;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		ram   = progImage;
		pc    = resetVector;
		count = 0;
		do begin
			instr   = ram[pc[9:2]];
			rs1v    = regs[instr[19:15]];
			rs2v    = regs[instr[24:20]];
			nextPc  = pc + 4;
			writeRd = 1'b1;
			res     = '0;
			case (instr[6:0])
				rType: res = refAlu(instr[14:12], rs1v, rs2v, instr[30]);
				iType: res = refAlu(instr[14:12], rs1v, {{20{instr[31]}}, instr[31:20]}, 1'b0);
				lwType: begin
					addr = rs1v + {{20{instr[31]}}, instr[31:20]};
					res  = ram[addr[9:2]];
				end
				sType: begin
					addr = rs1v + {{20{instr[31]}}, instr[31:25], instr[11:7]};
					ram[addr[9:2]] = rs2v;
					expAddr.push_back(addr);
					expData.push_back(rs2v);
					writeRd = 1'b0;
				end
				bType: begin
					if (rs1v == rs2v)
						nextPc = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
					writeRd = 1'b0;
				end
				jType: begin
					res    = pc + 4;
					nextPc = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
				end
				default: writeRd = 1'b0;
			endcase
			if (writeRd && instr[11:7] != 5'd0)
				regs[instr[11:7]] = res; // x0 never written
			done = (nextPc == pc);
			pc   = nextPc;
			count++;
		end while (!done && count < 1000);
		return count;
	endfunction

	// Each store against the next expected one
	always @(negedge clk) begin
		if (memWrite) begin
			assert (storesSeen < storeTotal)
				else failRun("A store happened after all expected stores were done");
			assert (memAddr == expAddr[storesSeen])
				else failRun($sformatf("Fail memAddr expected %h actual %h",
					expAddr[storesSeen], memAddr));
			assert (memWriteData == expData[storesSeen])
				else failRun($sformatf("Fail memWriteData expected %h actual %h",
					expData[storesSeen], memWriteData));
			storesSeen++;
		end
	end

	always @(posedge clk) begin
		if (rstN) begin
			cycleCount = cycleCount + 1;
			assert (cycleCount <= cycleLimit)
				else failRun($sformatf("Timeout after %0d cycles, the program did not finish",
					cycleCount));
		end
	end

	initial begin
		void'($urandom(32'ha61));
		rstN = 1'b0;
		buildProgram();
		nInstr     = refRun();
		storeTotal = expAddr.size();
		cycleLimit = 5 * nInstr + 200;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		assert (memAddr == resetVector)
			else failRun($sformatf("Fail memAddr expected %h actual %h", resetVector, memAddr));
		while (storesSeen < storeTotal)
			@(negedge clk);
		while (memAddr != loopAddr) // Fetch of the final jal
			@(negedge clk);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* registerFile.sv */
`timescale 1ns/1ps

module registerFile (
	input  logic              clk,
	input  logic              rstN,
	input  rvIsaPkg::regIndex Addr1,
	input  rvIsaPkg::regIndex Addr2,
	input  rvIsaPkg::regIndex Addr3,
	input  logic              regWrite,
	input  rvIsaPkg::dataWord dataIn,
	output rvIsaPkg::dataWord baseAddr,
	output rvIsaPkg::dataWord writeData
);

	import rvIsaPkg::*;

	dataWord regs [regCount];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end else if (regWrite && (Addr3 != '0)) begin
			regs[Addr3] <= dataIn; // x0 stays zero
		end
	end

	// rs1 and rs2 read ports
	assign baseAddr  = (Addr1 == '0) ? '0 : regs[Addr1];
	assign writeData = (Addr2 == '0) ? '0 : regs[Addr2];

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module multiCycleCore_tb \
	-f multiCycleCore.f \
	-o multiCycleCore_sim

if ./obj_dir/multiCycleCore_sim 2>&1 | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null; then
	echo "run.sh: simulation reported success"
else
	echo "run.sh: simulation reported failure"
	exit 1
fi

/* rvCtrlPkg.sv */
package rvCtrlPkg;

	// Multicycle control states
	typedef enum logic [3:0] {
		fetch, decode, memAdr, memRead, memWb, memWrite,
		executeR, executeI, aluWb, beqExec, jalExec
	} fsmState;

	// Operation class from the FSM to the ALU decoder
	typedef logic [1:0] aluOpSel;
	localparam aluOpSel aluOpAdd   = 2'b00;
	localparam aluOpSel aluOpSub   = 2'b01;
	localparam aluOpSel aluOpFunct = 2'b10; // Decided by funct3 and funct7

	// ALU operation codes
	typedef logic [2:0] aluCtrl;
	localparam aluCtrl aluAdd = 3'b000;
	localparam aluCtrl aluSub = 3'b001;
	localparam aluCtrl aluAnd = 3'b010;
	localparam aluCtrl aluOr  = 3'b011;
	localparam aluCtrl aluSlt = 3'b101;

	// Datapath mux selects
	typedef logic [1:0] srcSel;
	localparam srcSel srcAPc    = 2'b00;
	localparam srcSel srcAOldPc = 2'b01;
	localparam srcSel srcAReg   = 2'b10;
	localparam srcSel srcBReg   = 2'b00;
	localparam srcSel srcBImm   = 2'b01;
	localparam srcSel srcBFour  = 2'b10;
	localparam srcSel resAluOut    = 2'b00;
	localparam srcSel resData      = 2'b01;
	localparam srcSel resAluResult = 2'b10;

endpackage

/* rvIsaPkg.sv */
package rvIsaPkg;

	// Field and word widths of the RV32I subset
	typedef logic [31:0] dataWord; // Data, addresses and instructions
	typedef logic [4:0]  regIndex;
	typedef logic [6:0]  opcodeField;
	typedef logic [2:0]  funct3Field;
	typedef logic [6:0]  funct7Field;

	localparam int regCount = 32;

	// Major opcodes
	localparam opcodeField rType  = 7'b0110011; // add, sub, and, or, slt
	localparam opcodeField iType  = 7'b0010011; // addi, andi, ori, slti
	localparam opcodeField lwType = 7'b0000011;
	localparam opcodeField sType  = 7'b0100011;
	localparam opcodeField bType  = 7'b1100011; // beq only
	localparam opcodeField jType  = 7'b1101111; // jal

	// funct3 values of the ALU operations
	localparam funct3Field f3AddSub = 3'b000;
	localparam funct3Field f3Slt    = 3'b010;
	localparam funct3Field f3Or     = 3'b110;
	localparam funct3Field f3And    = 3'b111;

	// Bit of funct7 that turns add into sub
	localparam int funct7SubBit = 5;

endpackage
